// File: Bender.yml
package:
  name: eth_mac

sources:
  - logic/eth_pkg.sv
  - logic/eth_crc32.sv
  - logic/packet_ring.sv
  - logic/eth_tx_framer.sv
  - logic/eth_rx_deframer.sv
  - logic/host_regs.sv
  - logic/eth_mac_top.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/tb_eth_mac_assert.sv
      - sim/tb_eth_mac.sv

// File: flist.f
logic/eth_pkg.sv
logic/eth_crc32.sv
logic/packet_ring.sv
logic/eth_tx_framer.sv
logic/eth_rx_deframer.sv
logic/host_regs.sv
logic/eth_mac_top.sv
sim/clock_gen.sv
sim/tb_eth_mac_assert.sv
sim/tb_eth_mac.sv

// File: logic/eth_crc32.sv
module eth_crc32 (
    input  logic        clock,
    input  logic        reset,
    input  logic        init,
    input  logic        enable,
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    logic [31:0] crc_next;

    // one byte, lsb first, shift-right form
    always_comb begin
        crc_next = crc;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data[i]) begin
                crc_next = (crc_next >> 1) ^ eth_pkg::crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || init) begin
            crc <= eth_pkg::crc_init;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

// File: logic/eth_mac_top.sv
module eth_mac_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [eth_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [eth_pkg::data_w-1:0] wdata,
    input  logic [eth_pkg::data_w/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [eth_pkg::addr_w-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [eth_pkg::data_w-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [7:0]                 gmii_txd,
    output logic                       gmii_tx_en,
    output logic                       gmii_tx_er,
    input  logic [7:0]                 gmii_rxd,
    input  logic                       gmii_rx_dv,
    input  logic                       gmii_rx_er
);

    logic tx_wr_en;
    logic [eth_pkg::pkt_w-1:0] tx_wr_index;
    logic [7:0] tx_wr_byte;
    logic tx_commit;
    logic [eth_pkg::pkt_w-1:0] tx_commit_len;
    logic tx_full;
    logic [eth_pkg::pkt_w-1:0] tx_rd_index;
    logic [7:0] tx_rd_byte;
    logic [eth_pkg::pkt_w-1:0] tx_rd_len;
    logic tx_release;
    logic tx_empty;

    logic rx_wr_en;
    logic [eth_pkg::pkt_w-1:0] rx_wr_index;
    logic [7:0] rx_wr_byte;
    logic rx_commit;
    logic [eth_pkg::pkt_w-1:0] rx_commit_len;
    logic rx_full;
    logic [eth_pkg::pkt_w-1:0] rx_rd_index;
    logic [7:0] rx_rd_byte;
    logic [eth_pkg::pkt_w-1:0] rx_rd_len;
    logic rx_release;
    logic rx_empty;

    host_regs host_regs_i (
        .clock, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .wr_en(tx_wr_en), .wr_index(tx_wr_index), .wr_byte(tx_wr_byte),
        .commit(tx_commit), .commit_len(tx_commit_len), .full(tx_full),
        .rd_index(rx_rd_index), .rd_byte(rx_rd_byte), .rd_len(rx_rd_len),
        .empty(rx_empty), .release_slot(rx_release)
    );

    packet_ring tx_ring_i (
        .clock, .reset,
        .wr_en(tx_wr_en), .wr_index(tx_wr_index), .wr_byte(tx_wr_byte),
        .commit(tx_commit), .commit_len(tx_commit_len), .full(tx_full),
        .rd_index(tx_rd_index), .rd_byte(tx_rd_byte), .rd_len(tx_rd_len),
        .release_slot(tx_release), .empty(tx_empty)
    );

    packet_ring rx_ring_i (
        .clock, .reset,
        .wr_en(rx_wr_en), .wr_index(rx_wr_index), .wr_byte(rx_wr_byte),
        .commit(rx_commit), .commit_len(rx_commit_len), .full(rx_full),
        .rd_index(rx_rd_index), .rd_byte(rx_rd_byte), .rd_len(rx_rd_len),
        .release_slot(rx_release), .empty(rx_empty)
    );

    eth_tx_framer tx_framer_i (
        .clock, .reset,
        .rd_index(tx_rd_index), .rd_byte(tx_rd_byte), .rd_len(tx_rd_len),
        .empty(tx_empty), .release_slot(tx_release),
        .gmii_txd, .gmii_tx_en, .gmii_tx_er
    );

    eth_rx_deframer rx_deframer_i (
        .clock, .reset,
        .gmii_rxd, .gmii_rx_dv, .gmii_rx_er,
        .wr_en(rx_wr_en), .wr_index(rx_wr_index), .wr_byte(rx_wr_byte),
        .commit(rx_commit), .commit_len(rx_commit_len), .full(rx_full)
    );

endmodule

// File: logic/eth_pkg.sv
package eth_pkg;

    localparam int slots = 4;
    localparam int slot_w = 2;
    localparam int pkt_bytes = 64;
    localparam int pkt_w = 7;
    localparam int addr_w = 12;
    localparam int data_w = 32;

    localparam logic [addr_w-1:0] reg_tx_commit = 12'h000;
    localparam logic [addr_w-1:0] reg_status = 12'h004;
    localparam logic [addr_w-1:0] reg_rx_len = 12'h008;
    localparam logic [addr_w-1:0] reg_rx_release = 12'h00C;
    localparam logic [addr_w-1:0] tx_window = 12'h400;  // byte i at +4*i
    localparam logic [addr_w-1:0] rx_window = 12'h800;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte = 8'hD5;
    localparam int preamble_len = 7;
    localparam int ifg_cycles = 12;
    localparam logic [pkt_w-1:0] fcs_bytes = 7'd4;

    localparam logic [31:0] crc_init = 32'hFFFF_FFFF;
    localparam logic [31:0] crc_poly = 32'hEDB8_8320;  // 802.3, reflected
    localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

    localparam logic [2:0] tx_idle = 3'd0;
    localparam logic [2:0] tx_preamble = 3'd1;
    localparam logic [2:0] tx_sfd = 3'd2;
    localparam logic [2:0] tx_data = 3'd3;
    localparam logic [2:0] tx_fcs = 3'd4;
    localparam logic [2:0] tx_gap = 3'd5;

    localparam logic [1:0] rx_idle = 2'd0;
    localparam logic [1:0] rx_preamble = 2'd1;
    localparam logic [1:0] rx_data = 2'd2;
    localparam logic [1:0] rx_drop = 2'd3;  // wait for rx_dv low

endpackage

// File: logic/eth_rx_deframer.sv
module eth_rx_deframer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [7:0]                gmii_rxd,
    input  logic                      gmii_rx_dv,
    input  logic                      gmii_rx_er,
    output logic                      wr_en,
    output logic [eth_pkg::pkt_w-1:0] wr_index,
    output logic [7:0]                wr_byte,
    output logic                      commit,
    output logic [eth_pkg::pkt_w-1:0] commit_len,
    input  logic                      full
);

    logic [1:0] state;
    logic [eth_pkg::pkt_w-1:0] cnt;
    logic [31:0] crc;
    logic taking;
    logic frame_ok;

    // a good byte that still fits payload plus fcs
    assign taking = state == eth_pkg::rx_data && gmii_rx_dv && !gmii_rx_er
                    && cnt != eth_pkg::pkt_bytes + eth_pkg::fcs_bytes;

    assign wr_en = taking && cnt < eth_pkg::pkt_bytes;  // fcs bytes of a full frame not stored
    assign wr_index = cnt;
    assign wr_byte = gmii_rxd;

    assign frame_ok = crc == eth_pkg::crc_residue && cnt >= eth_pkg::fcs_bytes + 1
                      && cnt <= eth_pkg::pkt_bytes + eth_pkg::fcs_bytes && !full;
    assign commit = state == eth_pkg::rx_data && !gmii_rx_dv && frame_ok;
    assign commit_len = cnt - eth_pkg::fcs_bytes;

    eth_crc32 crc_i (
        .clock  (clock),
        .reset  (reset),
        .init   (state == eth_pkg::rx_preamble),
        .enable (taking),
        .data   (gmii_rxd),
        .crc    (crc)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= eth_pkg::rx_idle;
            cnt <= '0;
        end else if (!gmii_rx_dv) begin
            state <= eth_pkg::rx_idle;  // frame end, commit decided above
        end else begin
            case (state)
                eth_pkg::rx_idle: begin
                    cnt <= 7'd1;
                    if (gmii_rxd == eth_pkg::preamble_byte && !gmii_rx_er) begin
                        state <= eth_pkg::rx_preamble;
                    end else begin
                        state <= eth_pkg::rx_drop;
                    end
                end
                eth_pkg::rx_preamble: begin
                    cnt <= cnt + 1'b1;
                    if (gmii_rx_er) begin
                        state <= eth_pkg::rx_drop;
                    end else if (cnt < eth_pkg::preamble_len) begin
                        if (gmii_rxd != eth_pkg::preamble_byte) begin
                            state <= eth_pkg::rx_drop;
                        end
                    end else if (gmii_rxd == eth_pkg::sfd_byte && !full) begin
                        cnt <= '0;
                        state <= eth_pkg::rx_data;
                    end else begin
                        state <= eth_pkg::rx_drop;  // bad sfd, or no slot to fill
                    end
                end
                eth_pkg::rx_data: begin
                    if (taking) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        state <= eth_pkg::rx_drop;  // rx_er or overflow
                    end
                end
                default: state <= eth_pkg::rx_drop;
            endcase
        end
    end

endmodule

// File: logic/eth_tx_framer.sv
module eth_tx_framer (
    input  logic                      clock,
    input  logic                      reset,
    output logic [eth_pkg::pkt_w-1:0] rd_index,
    input  logic [7:0]                rd_byte,
    input  logic [eth_pkg::pkt_w-1:0] rd_len,
    input  logic                      empty,
    output logic                      release_slot,
    output logic [7:0]                gmii_txd,
    output logic                      gmii_tx_en,
    output logic                      gmii_tx_er
);

    logic [2:0] state;
    logic [eth_pkg::pkt_w-1:0] cnt;  // preamble, byte, fcs and gap counter
    logic [31:0] crc;

    eth_crc32 crc_i (
        .clock  (clock),
        .reset  (reset),
        .init   (state == eth_pkg::tx_idle),
        .enable (state == eth_pkg::tx_data),
        .data   (rd_byte),
        .crc    (crc)
    );

    assign rd_index = cnt;
    assign gmii_tx_er = 1'b0;
    assign release_slot = state == eth_pkg::tx_fcs && cnt == eth_pkg::fcs_bytes - 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= eth_pkg::tx_idle;
            cnt <= '0;
            gmii_txd <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                eth_pkg::tx_idle: begin
                    if (!empty) begin
                        gmii_txd <= eth_pkg::preamble_byte;
                        gmii_tx_en <= 1'b1;
                        cnt <= 7'd1;  // first preamble byte goes out now
                        state <= eth_pkg::tx_preamble;
                    end
                end
                eth_pkg::tx_preamble: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == eth_pkg::preamble_len - 1) begin
                        state <= eth_pkg::tx_sfd;
                    end
                end
                eth_pkg::tx_sfd: begin
                    gmii_txd <= eth_pkg::sfd_byte;
                    cnt <= '0;
                    state <= eth_pkg::tx_data;
                end
                eth_pkg::tx_data: begin
                    gmii_txd <= rd_byte;
                    cnt <= cnt + 1'b1;
                    if (cnt == rd_len - 1'b1) begin
                        cnt <= '0;
                        state <= eth_pkg::tx_fcs;
                    end
                end
                eth_pkg::tx_fcs: begin
                    gmii_txd <= ~crc[{cnt[1:0], 3'b000} +: 8];  // low byte first
                    cnt <= cnt + 1'b1;
                    if (release_slot) begin
                        cnt <= '0;
                        state <= eth_pkg::tx_gap;
                    end
                end
                eth_pkg::tx_gap: begin
                    gmii_txd <= '0;
                    gmii_tx_en <= 1'b0;
                    cnt <= cnt + 1'b1;
                    if (cnt == eth_pkg::ifg_cycles - 1) begin
                        cnt <= '0;
                        state <= eth_pkg::tx_idle;
                    end
                end
                default: state <= eth_pkg::tx_idle;
            endcase
        end
    end

endmodule

// File: logic/host_regs.sv
module host_regs (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [eth_pkg::addr_w-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [eth_pkg::data_w-1:0] wdata,
    input  logic [eth_pkg::data_w/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [eth_pkg::addr_w-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [eth_pkg::data_w-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       wr_en,
    output logic [eth_pkg::pkt_w-1:0]  wr_index,
    output logic [7:0]                 wr_byte,
    output logic                       commit,
    output logic [eth_pkg::pkt_w-1:0]  commit_len,
    input  logic                       full,
    output logic [eth_pkg::pkt_w-1:0]  rd_index,
    input  logic [7:0]                 rd_byte,
    input  logic [eth_pkg::pkt_w-1:0]  rd_len,
    input  logic                       empty,
    output logic                       release_slot
);

    logic aw_tx_win;
    logic aw_commit;
    logic aw_release;
    logic ar_rx_win;
    logic len_ok;
    logic strobed;
    logic [1:0] wr_resp;
    logic [1:0] rd_resp;
    logic [eth_pkg::data_w-1:0] rd_data;

    assign wready = awready;  // address and data taken together
    assign strobed = |wstrb;
    assign len_ok = wdata != '0 && wdata <= eth_pkg::pkt_bytes;

    assign aw_tx_win = awaddr >= eth_pkg::tx_window
                       && awaddr < eth_pkg::tx_window + 4 * eth_pkg::pkt_bytes;
    assign ar_rx_win = araddr >= eth_pkg::rx_window
                       && araddr < eth_pkg::rx_window + 4 * eth_pkg::pkt_bytes;
    assign aw_commit = awaddr == eth_pkg::reg_tx_commit;
    assign aw_release = awaddr == eth_pkg::reg_rx_release;

    // side effects fire in the transfer cycle
    assign wr_en = awready && aw_tx_win && wstrb[0];
    assign wr_index = awaddr[eth_pkg::pkt_w+1:2];
    assign wr_byte = wdata[7:0];
    assign commit = awready && aw_commit && strobed && len_ok && !full;
    assign commit_len = wdata[eth_pkg::pkt_w-1:0];
    assign release_slot = awready && aw_release && strobed && !empty;
    assign wr_resp = (aw_tx_win || (aw_commit && len_ok && !full) || (aw_release && !empty))
                     ? eth_pkg::resp_okay : eth_pkg::resp_slverr;

    assign rd_index = araddr[eth_pkg::pkt_w+1:2];

    always_comb begin
        rd_data = '0;
        rd_resp = eth_pkg::resp_okay;
        if (araddr == eth_pkg::reg_status) begin
            rd_data[0] = full;
            rd_data[1] = empty;
        end else if (araddr == eth_pkg::reg_rx_len) begin
            rd_data[eth_pkg::pkt_w-1:0] = empty ? '0 : rd_len;
        end else if (ar_rx_win) begin
            rd_data[7:0] = rd_byte;
        end else begin
            rd_resp = eth_pkg::resp_slverr;  // unmapped or write-only
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            awready <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            awready <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (awready) begin
                bvalid <= 1'b1;
                bresp <= wr_resp;
            end else if (awvalid && wvalid && !bvalid) begin
                awready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid <= 1'b1;
            rdata <= rd_data;
            rresp <= rd_resp;
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                arready <= 1'b1;
            end
        end else begin
            arready <= 1'b1;
        end
    end

endmodule

// File: logic/packet_ring.sv
module packet_ring (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      wr_en,
    input  logic [eth_pkg::pkt_w-1:0] wr_index,
    input  logic [7:0]                wr_byte,
    input  logic                      commit,
    input  logic [eth_pkg::pkt_w-1:0] commit_len,
    output logic                      full,
    input  logic [eth_pkg::pkt_w-1:0] rd_index,
    output logic [7:0]                rd_byte,
    output logic [eth_pkg::pkt_w-1:0] rd_len,
    input  logic                      release_slot,
    output logic                      empty
);

    logic [7:0] mem [eth_pkg::slots][eth_pkg::pkt_bytes];
    logic [eth_pkg::pkt_w-1:0] len_q [eth_pkg::slots];
    logic [eth_pkg::slot_w-1:0] head;
    logic [eth_pkg::slot_w-1:0] tail;
    logic [eth_pkg::slot_w:0] count;
    logic do_commit;
    logic do_release;

    assign full = count == eth_pkg::slots;
    assign empty = count == '0;
    assign do_commit = commit && !full;
    assign do_release = release_slot && !empty;

    assign rd_byte = mem[head][rd_index[eth_pkg::pkt_w-2:0]];
    assign rd_len = len_q[head];

    always_ff @(posedge clock) begin
        if (wr_en && wr_index < eth_pkg::pkt_bytes) begin
            mem[tail][wr_index[eth_pkg::pkt_w-2:0]] <= wr_byte;  // always the open slot
        end
        if (do_commit) begin
            len_q[tail] <= commit_len;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (do_commit) begin
                tail <= tail + 1'b1;
            end
            if (do_release) begin
                head <= head + 1'b1;
            end
            case ({do_commit, do_release})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // none, or both at once
            endcase
        end
    end

endmodule

// File: sim/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #5 reset = 1'b0;  // just after the second edge
    end

endmodule

// File: sim/tb_eth_mac.sv
module tb_eth_mac;

    localparam int skew = 10;  // input drive delay after the edge
    localparam int frame_len = 20;
    localparam int max_rows = 128;
    localparam int wait_limit = 20;
    localparam int frame_limit = 400;
    localparam int flip_pos = 5;  // payload byte hit by corruption

    localparam int op_write = 0;
    localparam int op_read = 1;
    localparam int op_send = 2;
    localparam int op_wait_rx = 3;

    logic clock;
    logic reset;
    logic [eth_pkg::addr_w-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [eth_pkg::data_w-1:0] wdata;
    logic [eth_pkg::data_w/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [eth_pkg::addr_w-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [eth_pkg::data_w-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [7:0] gmii_txd;
    logic gmii_tx_en;
    logic gmii_tx_er;
    logic [7:0] gmii_rxd;
    logic gmii_rx_dv;
    logic gmii_rx_er;

    int op_tab [max_rows];
    logic [eth_pkg::addr_w-1:0] addr_tab [max_rows];
    logic [31:0] data_tab [max_rows];
    logic [1:0] resp_tab [max_rows];
    logic [31:0] rval_tab [max_rows];
    bit corrupt_tab [max_rows];
    int rows;

    logic [7:0] payload [frame_len];
    logic [7:0] line_q [$];  // bytes seen on gmii_txd
    bit corrupt;
    int burst_pos;
    int seed;
    int errors;
    int timeouts;

    clock_gen clock_gen_i (.clock(clock), .reset(reset));

    eth_mac_top dut_i (
        .clock, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .gmii_txd, .gmii_tx_en, .gmii_tx_er,
        .gmii_rxd, .gmii_rx_dv, .gmii_rx_er
    );

    // line loopback, one cycle late
    always @(posedge clock) begin
        #skew;
        if (gmii_tx_en === 1'b1) begin
            line_q.push_back(gmii_txd);
            if (corrupt && burst_pos == 8 + flip_pos) begin
                gmii_rxd = gmii_txd ^ 8'h01;
            end else begin
                gmii_rxd = gmii_txd;
            end
            burst_pos++;
        end else begin
            gmii_rxd = gmii_txd;
            burst_pos = 0;
        end
        gmii_rx_dv = gmii_tx_en;
        gmii_rx_er = gmii_tx_er;
    end

    function automatic logic [31:0] ref_fcs(input int len);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            c = c ^ {24'h0, payload[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
            end
        end
        return ~c;
    endfunction

    task automatic add_row(input int op, input logic [eth_pkg::addr_w-1:0] addr,
                           input logic [31:0] data, input logic [1:0] resp,
                           input logic [31:0] rval, input bit bad);
        op_tab[rows] = op;
        addr_tab[rows] = addr;
        data_tab[rows] = data;
        resp_tab[rows] = resp;
        rval_tab[rows] = rval;
        corrupt_tab[rows] = bad;
        rows++;
    endtask

    task automatic build_table();
        seed = 29;
        for (int i = 0; i < frame_len; i++) begin
            payload[i] = 8'($random(seed));
        end
        add_row(op_read, eth_pkg::reg_status, 0, eth_pkg::resp_okay, 32'h2, 0);
        add_row(op_read, eth_pkg::reg_rx_len, 0, eth_pkg::resp_okay, 32'h0, 0);
        for (int i = 0; i < frame_len; i++) begin
            add_row(op_write, eth_pkg::tx_window + 12'(4 * i), payload[i],
                    eth_pkg::resp_okay, 0, 0);
        end
        add_row(op_send, eth_pkg::reg_tx_commit, frame_len, eth_pkg::resp_okay, 0, 0);
        add_row(op_wait_rx, eth_pkg::reg_status, 0, eth_pkg::resp_okay, 0, 0);
        add_row(op_read, eth_pkg::reg_rx_len, 0, eth_pkg::resp_okay, frame_len, 0);
        for (int i = 0; i < frame_len; i++) begin
            add_row(op_read, eth_pkg::rx_window + 12'(4 * i), 0, eth_pkg::resp_okay,
                    {24'h0, payload[i]}, 0);
        end
        add_row(op_write, eth_pkg::reg_rx_release, 0, eth_pkg::resp_okay, 0, 0);
        add_row(op_read, eth_pkg::reg_status, 0, eth_pkg::resp_okay, 32'h2, 0);
        // same payload again, flipped on the line
        for (int i = 0; i < frame_len; i++) begin
            add_row(op_write, eth_pkg::tx_window + 12'(4 * i), payload[i],
                    eth_pkg::resp_okay, 0, 0);
        end
        add_row(op_send, eth_pkg::reg_tx_commit, frame_len, eth_pkg::resp_okay, 0, 1);
        add_row(op_read, eth_pkg::reg_status, 0, eth_pkg::resp_okay, 32'h2, 0);
        add_row(op_write, eth_pkg::reg_tx_commit, 0, eth_pkg::resp_slverr, 0, 0);
        add_row(op_write, eth_pkg::reg_tx_commit, 65, eth_pkg::resp_slverr, 0, 0);
        add_row(op_write, eth_pkg::reg_rx_release, 0, eth_pkg::resp_slverr, 0, 0);
        add_row(op_write, 12'h010, 0, eth_pkg::resp_slverr, 0, 0);
        add_row(op_read, 12'h010, 0, eth_pkg::resp_slverr, 0, 0);
        add_row(op_read, eth_pkg::reg_tx_commit, 0, eth_pkg::resp_slverr, 0, 0);
        add_row(op_write, eth_pkg::reg_status, 0, eth_pkg::resp_slverr, 0, 0);
        for (int i = 0; i < eth_pkg::slots; i++) begin
            add_row(op_write, eth_pkg::reg_tx_commit, 64, eth_pkg::resp_okay, 0, 0);
        end
        add_row(op_write, eth_pkg::reg_tx_commit, 64, eth_pkg::resp_slverr, 0, 0);
        add_row(op_read, eth_pkg::reg_status, 0, eth_pkg::resp_okay, 32'h3, 0);
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic axi_write(input logic [eth_pkg::addr_w-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        awaddr = addr;
        wdata = data;
        wstrb = 4'hF;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        while (!(awready && wready) && n < wait_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (!(awready && wready)) begin
            report_timeout("awready and wready");
        end
        @(posedge clock);  // address and data taken here
        #skew;
        awvalid = 1'b0;
        wvalid = 1'b0;
        n = 0;
        while (!bvalid && n < wait_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (!bvalid) begin
            report_timeout("bvalid");
        end
        @(posedge clock);  // one cycle of back-pressure
        #skew;
        bready = 1'b1;
        resp = bresp;
        @(posedge clock);
        #skew;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [eth_pkg::addr_w-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < wait_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (!arready) begin
            report_timeout("arready");
        end
        @(posedge clock);
        #skew;
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < wait_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (!rvalid) begin
            report_timeout("rvalid");
        end
        @(posedge clock);  // one cycle of back-pressure
        #skew;
        rready = 1'b1;
        data = rdata;
        resp = rresp;
        @(posedge clock);
        #skew;
        rready = 1'b0;
    endtask

    task automatic check_line(input int len);
        logic [7:0] exp_q [$];
        logic [31:0] fcs;
        fcs = ref_fcs(len);
        for (int i = 0; i < eth_pkg::preamble_len; i++) begin
            exp_q.push_back(eth_pkg::preamble_byte);
        end
        exp_q.push_back(eth_pkg::sfd_byte);
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(payload[i]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(fcs[8*k +: 8]);  // low byte first
        end
        if (line_q.size() != exp_q.size()) begin
            errors++;
            $display("** Error: gmii_tx_en burst length: got %h, expected %h",
                     line_q.size(), exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < line_q.size(); i++) begin
            if (line_q[i] !== exp_q[i]) begin
                errors++;
                $display("** Error: gmii_txd byte %0d: got %h, expected %h",
                         i, line_q[i], exp_q[i]);
            end
        end
    endtask

    task automatic send_frame(input int r);
        logic [1:0] resp;
        int n;
        corrupt = corrupt_tab[r];
        line_q.delete();
        axi_write(addr_tab[r], data_tab[r], resp);
        if (resp !== resp_tab[r]) begin
            errors++;
            $display("** Error: bresp at row %0d: got %h, expected %h", r, resp, resp_tab[r]);
        end
        n = 0;
        while (!gmii_tx_en && n < frame_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (!gmii_tx_en) begin
            report_timeout("gmii_tx_en to rise");
        end
        n = 0;
        while (gmii_tx_en && n < frame_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (gmii_tx_en) begin
            report_timeout("gmii_tx_en to fall");
        end
        repeat (eth_pkg::ifg_cycles) @(posedge clock);
        #skew;
        check_line(data_tab[r]);
    endtask

    task automatic wait_rx();
        logic [31:0] status;
        logic [1:0] resp;
        int n;
        n = 0;
        axi_read(eth_pkg::reg_status, status, resp);
        while (status[1] && n < wait_limit) begin
            axi_read(eth_pkg::reg_status, status, resp);
            n++;
        end
        if (status[1]) begin
            report_timeout("a received frame");
        end
    endtask

    initial begin
        logic [1:0] resp;
        logic [31:0] value;
        int n;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        gmii_rxd = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        errors = 0;
        timeouts = 0;
        rows = 0;
        corrupt = 1'b0;
        burst_pos = 0;
        build_table();

        n = 0;
        while (reset !== 1'b0 && n < wait_limit) begin
            @(posedge clock);
            #skew;
            n++;
        end
        if (reset !== 1'b0) begin
            report_timeout("reset release");
        end
        @(posedge clock);
        #skew;
        if (gmii_tx_en !== 1'b0) begin
            errors++;
            $display("** Error: gmii_tx_en after reset: got %h, expected %h", gmii_tx_en, 1'b0);
        end

        for (int r = 0; r < rows && timeouts == 0; r++) begin
            case (op_tab[r])
                op_write: begin
                    axi_write(addr_tab[r], data_tab[r], resp);
                    if (resp !== resp_tab[r]) begin
                        errors++;
                        $display("** Error: bresp at row %0d: got %h, expected %h",
                                 r, resp, resp_tab[r]);
                    end
                end
                op_read: begin
                    axi_read(addr_tab[r], value, resp);
                    if (resp !== resp_tab[r]) begin
                        errors++;
                        $display("** Error: rresp at row %0d: got %h, expected %h",
                                 r, resp, resp_tab[r]);
                    end
                    if (value !== rval_tab[r]) begin
                        errors++;
                        $display("** Error: rdata at row %0d: got %h, expected %h",
                                 r, value, rval_tab[r]);
                    end
                end
                op_send: send_frame(r);
                op_wait_rx: wait_rx();
                default: begin
                    errors++;
                    $display("row %0d holds an unknown operation", r);
                end
            endcase
        end

        $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, dut_i.assert_i.failures);
        if (errors == 0 && timeouts == 0 && dut_i.assert_i.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim/tb_eth_mac_assert.sv
module tb_eth_mac_assert (
    input logic       clock,
    input logic       reset,
    input logic [7:0] gmii_txd,
    input logic       gmii_tx_en,
    input logic       gmii_tx_er,
    input logic       bvalid,
    input logic       bready,
    input logic       rvalid,
    input logic       rready
);

    int failures = 0;

    tx_er_low: assert property (@(posedge clock) disable iff (reset) !gmii_tx_er)
        else begin
            failures++;
            $error("gmii_tx_er went high");
        end

    bvalid_held: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            failures++;
            $error("bvalid dropped before bready");
        end

    rvalid_held: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else begin
            failures++;
            $error("rvalid dropped before rready");
        end

    // every burst opens with a preamble byte
    burst_start: assert property (@(posedge clock) disable iff (reset)
        $rose(gmii_tx_en) |-> gmii_txd == eth_pkg::preamble_byte)
        else begin
            failures++;
            $error("tx burst did not start with preamble");
        end

endmodule

bind eth_mac_top tb_eth_mac_assert assert_i (
    .clock(clock), .reset(reset),
    .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);
